//--- build.f
+incdir+common
common/pc_enc_pkg.sv
rtl/pc_enc_buffer.sv
rtl/pc_enc_unload.sv
enc/pc_enc_ctrl.sv
enc/pc_enc_alu.sv
enc/pc_enc_engine.sv
rtl/pc_enc_top.sv
verif/pc_enc_props.sv
verif/tb_pc_enc.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the polar encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_pc_enc -f build.f -o tb_pc_enc \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_pc_enc > sim.log 2>&1 ; cat sim.log

grep -q -F -- '*** FAILED ***' sim.log && { echo "Simulation failed"; exit 1; }
grep -q -F -- '*** PASSED ***' sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

//--- verif/tb_pc_enc.sv
`include "pc_enc_config.svh"

module tb_pc_enc;

  localparam int N       = `PC_N;
  localparam int WORDS   = `PC_WORDS;
  localparam int WORD_W  = `PC_WORD_W;
  localparam int TIMEOUT = 1000;

  logic              iclk;
  logic              ireset;
  logic              iclkena;
  logic              in_valid;
  pc_enc_pkg::word_t in_word;
  logic              frame_full;
  logic              busy;
  logic              out_valid;
  pc_enc_pkg::word_t out_word;
  logic              out_last;

  // Galois LFSR state
  logic [31:0] lfsr;
  // Coded words still to come in output order
  logic [`PC_WORD_W-1:0] exp_q [$];
  int words_sent;
  int words_seen;
  // Random iclkena drops
  bit gate_on;

  pc_enc_top dut (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .frame_full (frame_full),
    .busy       (busy),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_last   (out_last)
  );

  initial begin
    iclk = 1'b0;
    forever begin
      #50 iclk = ~iclk;
    end
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'h80200003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // Clock enable for the next edge drops one time in four when gated
  function automatic logic pick_enable();
    if (!gate_on) begin
      return 1'b1;
    end
    return rand_bits(2) != 0;
  endfunction

  // Coded bit j is XOR of all u[i] with (i & j) == j
  function automatic logic [`PC_N-1:0] polar_encode(input logic [`PC_N-1:0] u);
    logic [`PC_N-1:0] c;
    int               i;
    int               j;
    c = '0;
    for (j = 0; j < N; j++) begin
      for (i = 0; i < N; i++) begin
        if ((i & j) == j) begin
          c[j] = c[j] ^ u[i];
        end
      end
    end
    return c;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("** Error at time %0t: %s is %0h, expected %0h",
                          $time, name, got, want));
    end
  endtask

  //------------------------------------------------------------
  // Frame writer
  //------------------------------------------------------------

  task automatic send_frame(input logic [`PC_N-1:0] frame);
    logic [`PC_N-1:0] coded;
    logic [31:0]      r;
    int               w;
    int               wait_cnt;
    coded = polar_encode(frame);
    for (w = 0; w < WORDS; w++) begin
      exp_q.push_back(coded[w*WORD_W +: WORD_W]);
    end
    words_sent += WORDS;
    w = 0;
    wait_cnt = 0;
    while (w < WORDS) begin
      @(negedge iclk);
      iclkena = pick_enable();
      if (frame_full) begin
        // Junk write that the full buffer must drop
        r            = rand_bits(WORD_W);
        in_valid     = 1'b1;
        in_word.bits = r[WORD_W-1:0];
      end else if (rand_bits(2) == 0) begin
        in_valid = 1'b0;
      end else begin
        in_valid     = 1'b1;
        in_word.bits = frame[w*WORD_W +: WORD_W];
        // Taken only on an enabled edge
        if (iclkena) begin
          w++;
        end
      end
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        abort_run("Timeout: the source buffer stopped taking input words");
      end
    end
  endtask

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------

  initial begin
    logic [`PC_N-1:0] f;
    logic [31:0]      r;
    int               i;
    int               w;
    int               wait_cnt;
    lfsr       = 32'hd6638c45;
    ireset     = 1'b1;
    iclkena    = 1'b1;
    in_valid   = 1'b0;
    in_word    = '0;
    gate_on    = 1'b0;
    words_sent = 0;
    repeat (16) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    @(negedge iclk);
    check_equal("out_valid", 32'(out_valid), 0);
    check_equal("out_last", 32'(out_last), 0);
    check_equal("busy", 32'(busy), 0);
    check_equal("frame_full", 32'(frame_full), 0);
    // Unit vectors give the generator rows
    for (i = 0; i < N; i++) begin
      f    = '0;
      f[i] = 1'b1;
      send_frame(f);
    end
    // Random frames with iclkena drops in the second half
    for (i = 0; i < 32; i++) begin
      gate_on = (i >= 16);
      for (w = 0; w < WORDS; w++) begin
        r = rand_bits(WORD_W);
        f[w*WORD_W +: WORD_W] = r[WORD_W-1:0];
      end
      send_frame(f);
    end
    // Drain the pipeline
    wait_cnt = 0;
    while (words_seen < words_sent) begin
      @(negedge iclk);
      iclkena  = pick_enable();
      in_valid = 1'b0;
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        abort_run("Timeout: coded words missing at the output");
      end
    end
    // Quiet window for stray output words
    gate_on = 1'b0;
    repeat (40) begin
      @(negedge iclk);
      iclkena = 1'b1;
    end
    if (busy === 1'b0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      // Engine idle once the last frame is out
      check_equal("busy", 32'(busy), 0);
    end
  end

  //------------------------------------------------------------
  // Output checker
  //------------------------------------------------------------

  initial begin
    logic [`PC_WORD_W-1:0] exp_word;
    int                    idx;
    words_seen = 0;
    idx        = 0;
    forever begin
      @(negedge iclk);
      if (!ireset && out_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("Output word arrived with no frame pending");
        end else begin
          exp_word = exp_q.pop_front();
          check_equal("out_word", 32'(out_word.bits), 32'(exp_word));
          check_equal("out_last", 32'(out_last), 32'(idx == WORDS - 1));
          idx = (idx + 1) % WORDS;
          words_seen++;
        end
      end
    end
  end

endmodule

//--- verif/pc_enc_props.sv
module pc_enc_props (
  input logic iclk,
  input logic ireset,
  input logic iclkena,
  input logic out_valid,
  input logic out_last,
  input logic busy,
  input logic snk_wvalid
);

  // Frame end always carries a word
  a_last_valid: assert property (@(posedge iclk) disable iff (ireset)
    out_last |-> out_valid) else $error("out_last without out_valid");

  a_reset_quiet: assert property (@(posedge iclk) ireset |-> !out_valid)
    else $error("out_valid high during reset");

  // Output strobe only follows an enabled edge
  a_valid_enabled: assert property (@(posedge iclk) disable iff (ireset)
    out_valid |-> $past(iclkena)) else $error("out_valid after disabled edge");

  // Engine idles together with its last sink write
  a_busy_store: assert property (@(posedge iclk) disable iff (ireset)
    $fell(busy) |-> snk_wvalid) else $error("busy fell without a sink write");

endmodule

bind pc_enc_top pc_enc_props u_props (
  .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
  .out_valid (out_valid), .out_last (out_last),
  .busy (busy), .snk_wvalid (snk_wvalid)
);

//--- rtl/pc_enc_top.sv
module pc_enc_top (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // Input frame words
  input  logic              in_valid,
  input  pc_enc_pkg::word_t in_word,
  output logic              frame_full,
  output logic              busy,
  // Coded frame words
  output logic              out_valid,
  output pc_enc_pkg::word_t out_word,
  output logic              out_last
);

  // Source buffer to engine
  logic              src_full;
  pc_enc_pkg::addr_t src_raddr;
  pc_enc_pkg::word_t src_rdata;
  logic              src_release;

  // Engine to sink buffer to unloader
  logic              snk_wvalid;
  pc_enc_pkg::word_t snk_wdata;
  logic              snk_full;
  pc_enc_pkg::addr_t snk_raddr;
  pc_enc_pkg::word_t snk_rdata;
  logic              snk_release;

  assign frame_full = src_full;

  //------------------------------------------------------------
  // Source buffer, engine, sink buffer, unloader
  //------------------------------------------------------------

  pc_enc_buffer u_src_buf (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .wvalid (in_valid), .wdata (in_word),
    .raddr (src_raddr), .frame_release (src_release),
    .rdata (src_rdata), .full (src_full)
  );

  pc_enc_engine u_engine (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .src_full (src_full), .src_raddr (src_raddr),
    .src_rdata (src_rdata), .src_release (src_release),
    .snk_full (snk_full), .snk_wvalid (snk_wvalid),
    .snk_wdata (snk_wdata), .busy (busy)
  );

  pc_enc_buffer u_snk_buf (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .wvalid (snk_wvalid), .wdata (snk_wdata),
    .raddr (snk_raddr), .frame_release (snk_release),
    .rdata (snk_rdata), .full (snk_full)
  );

  pc_enc_unload u_unload (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .full (snk_full), .rdata (snk_rdata),
    .raddr (snk_raddr), .frame_release (snk_release),
    .out_valid (out_valid), .out_word (out_word), .out_last (out_last)
  );

endmodule

//--- enc/pc_enc_engine.sv
module pc_enc_engine (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // Source buffer consumer
  input  logic              src_full,
  output pc_enc_pkg::addr_t src_raddr,
  input  pc_enc_pkg::word_t src_rdata,
  output logic              src_release,
  // Sink buffer producer
  input  logic              snk_full,
  output logic              snk_wvalid,
  output pc_enc_pkg::word_t snk_wdata,
  output logic              busy
);

  // Registered command, controller to ALU
  pc_enc_pkg::alu_cmd_t cmd;

  //------------------------------------------------------------
  // Sequencing
  //------------------------------------------------------------

  pc_enc_ctrl u_ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .src_full    (src_full),
    .snk_full    (snk_full),
    .src_raddr   (src_raddr),
    .src_release (src_release),
    .cmd         (cmd),
    .busy        (busy)
  );

  //------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------

  pc_enc_alu u_alu (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .cmd        (cmd),
    .src_rdata  (src_rdata),
    .snk_wvalid (snk_wvalid),
    .snk_wdata  (snk_wdata)
  );

endmodule

//--- enc/pc_enc_alu.sv
`include "pc_enc_config.svh"

module pc_enc_alu (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  // Command from controller
  input  pc_enc_pkg::alu_cmd_t cmd,
  // Source word, valid while LOAD executes
  input  pc_enc_pkg::word_t    src_rdata,
  // Sink write port
  output logic                 snk_wvalid,
  output pc_enc_pkg::word_t    snk_wdata
);

  //------------------------------------------------------------
  // In-word polar butterfly
  //------------------------------------------------------------

  // Bit p gets XOR of bit p + span, for every p with span bit clear
  function automatic pc_enc_pkg::word_t word_butterfly(input pc_enc_pkg::word_t w);
    logic [`PC_WORD_W-1:0] v;
    int                    st;
    int                    p;
    int                    span;
    v = w.bits;
    for (st = 0; st < `PC_WORD_STAGES; st++) begin
      span = 1 << st;
      for (p = 0; p < `PC_WORD_W; p++) begin
        if ((p & span) == 0) begin
          v[p] = v[p] ^ v[p + span];
        end
      end
    end
    return '{bits: v};
  endfunction

  // Working register file, one frame
  pc_enc_pkg::word_t work [`PC_WORDS];

  //------------------------------------------------------------
  // Execute
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      case (cmd.opcode)
        pc_enc_pkg::LOAD:  work[cmd.addr_a] <= word_butterfly(src_rdata);
        // Cross-word butterfly half
        pc_enc_pkg::XOR:   work[cmd.addr_a].bits <= work[cmd.addr_a].bits ^
                                                    work[cmd.addr_b].bits;
        pc_enc_pkg::STORE: snk_wdata <= work[cmd.addr_a];
        default: ;
      endcase
    end
  end

  // Sink write strobe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      snk_wvalid <= 1'b0;
    end else if (iclkena) begin
      snk_wvalid <= (cmd.opcode == pc_enc_pkg::STORE);
    end
  end

endmodule

//--- enc/pc_enc_ctrl.sv
`include "pc_enc_config.svh"

module pc_enc_ctrl (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  // Buffer status
  input  logic                 src_full,
  input  logic                 snk_full,
  // Source read side
  output pc_enc_pkg::addr_t    src_raddr,
  output logic                 src_release,
  // ALU command
  output pc_enc_pkg::alu_cmd_t cmd,
  output logic                 busy
);

  //------------------------------------------------------------
  // Constants and state
  //------------------------------------------------------------

  localparam pc_enc_pkg::addr_t LAST_WORD = pc_enc_pkg::addr_t'(`PC_WORDS - 1);
  localparam pc_enc_pkg::addr_t LAST_PAIR = pc_enc_pkg::addr_t'(`PC_WORDS / 2 - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_STAGE,
    S_WAIT_SINK,
    S_STORE
  } state_t;

  state_t state;

  // Word counter for load and store
  pc_enc_pkg::addr_t phi;
  // Pair counter inside one cross-word stage
  pc_enc_pkg::addr_t beta;
  // One-hot stage span, 1, 2, 4 ...
  pc_enc_pkg::addr_t span;

  // Pair address generation
  pc_enc_pkg::addr_t low_mask;
  pc_enc_pkg::addr_t pair_a;
  pc_enc_pkg::addr_t pair_b;

  //------------------------------------------------------------
  // Pair addresses
  //------------------------------------------------------------

  // Bits of beta below the span bit
  assign low_mask = span - 1'b1;
  // Zero inserted at span bit of beta
  assign pair_a   = ((beta & ~low_mask) << 1) | (beta & low_mask);
  // Partner word, span bit set
  assign pair_b   = pair_a | span;

  // Source word read during LOAD execution
  assign src_raddr = cmd.addr_a;

  //------------------------------------------------------------
  // FSM
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state       <= S_IDLE;
      phi         <= '0;
      beta        <= '0;
      span        <= pc_enc_pkg::addr_t'(1);
      cmd         <= '{opcode: pc_enc_pkg::NOP, addr_a: '0, addr_b: '0};
      src_release <= 1'b0;
      busy        <= 1'b0;
    end else if (iclkena) begin
      // Defaults, no operation and no release
      cmd.opcode  <= pc_enc_pkg::NOP;
      src_release <= 1'b0;
      case (state)
        S_IDLE: begin
          busy <= src_full;
          // First word issued on the start edge
          if (src_full) begin
            cmd   <= '{opcode: pc_enc_pkg::LOAD, addr_a: '0, addr_b: '0};
            phi   <= pc_enc_pkg::addr_t'(1);
            state <= S_LOAD;
          end
        end
        S_LOAD: begin
          cmd   <= '{opcode: pc_enc_pkg::LOAD, addr_a: phi, addr_b: '0};
          phi   <= phi + 1'b1;
          if (phi == LAST_WORD) begin
            // Source frame read out with this command
            src_release <= 1'b1;
            beta        <= '0;
            span        <= pc_enc_pkg::addr_t'(1);
            state       <= S_STAGE;
          end
        end
        S_STAGE: begin
          cmd  <= '{opcode: pc_enc_pkg::XOR, addr_a: pair_a, addr_b: pair_b};
          beta <= beta + 1'b1;
          if (beta == LAST_PAIR) begin
            // Stage done, double the span
            beta <= '0;
            span <= span << 1;
            if (span[`PC_ADDR_W-1]) begin
              state <= S_WAIT_SINK;
            end
          end
        end
        S_WAIT_SINK: begin
          // Sink still holds the previous frame
          if (!snk_full) begin
            cmd   <= '{opcode: pc_enc_pkg::STORE, addr_a: '0, addr_b: '0};
            phi   <= pc_enc_pkg::addr_t'(1);
            state <= S_STORE;
          end
        end
        S_STORE: begin
          cmd <= '{opcode: pc_enc_pkg::STORE, addr_a: phi, addr_b: '0};
          phi <= phi + 1'b1;
          if (phi == LAST_WORD) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/pc_enc_unload.sv
`include "pc_enc_config.svh"

module pc_enc_unload (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // Sink buffer side
  input  logic              full,
  input  pc_enc_pkg::word_t rdata,
  output pc_enc_pkg::addr_t raddr,
  output logic              frame_release,
  // Coded stream
  output logic              out_valid,
  output pc_enc_pkg::word_t out_word,
  output logic              out_last
);

  localparam pc_enc_pkg::addr_t LAST_WORD = pc_enc_pkg::addr_t'(`PC_WORDS - 1);

  // Word emitted this cycle, blocked while release is pending
  logic fire;

  assign fire = full && !frame_release;

  //------------------------------------------------------------
  // Address counter and strobes
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      raddr         <= '0;
      frame_release <= 1'b0;
      out_valid     <= 1'b0;
      out_last      <= 1'b0;
    end else begin
      // Strobes only after enabled edges
      out_valid <= iclkena && fire;
      out_last  <= iclkena && fire && (raddr == LAST_WORD);
      if (iclkena) begin
        // Held until the buffer takes it on an enabled edge
        frame_release <= fire && (raddr == LAST_WORD);
        if (fire) begin
          raddr <= raddr + 1'b1;
        end
      end
    end
  end

  // Output word register
  always_ff @(posedge iclk) begin
    if (iclkena && fire) begin
      out_word <= rdata;
    end
  end

endmodule

//--- rtl/pc_enc_buffer.sv
`include "pc_enc_config.svh"

module pc_enc_buffer (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // Sequential write side
  input  logic              wvalid,
  input  pc_enc_pkg::word_t wdata,
  // Addressed read side
  input  pc_enc_pkg::addr_t raddr,
  input  logic              frame_release,
  output pc_enc_pkg::word_t rdata,
  output logic              full
);

  //------------------------------------------------------------
  // Storage and write counter
  //------------------------------------------------------------

  localparam pc_enc_pkg::addr_t LAST_WORD = pc_enc_pkg::addr_t'(`PC_WORDS - 1);

  // One frame of words
  pc_enc_pkg::word_t mem [`PC_WORDS];

  // Next word slot to fill
  pc_enc_pkg::addr_t wcnt;

  // Write accepted only while buffer has room
  logic wr_en;

  assign wr_en = wvalid && !full;

  //------------------------------------------------------------
  // Fill state
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt <= '0;
      full <= 1'b0;
    end else if (iclkena) begin
      if (frame_release) begin
        // Consumer done, reopen for next frame
        wcnt <= '0;
        full <= 1'b0;
      end else if (wr_en) begin
        wcnt <= wcnt + 1'b1;
        // Last slot written
        if (wcnt == LAST_WORD) begin
          full <= 1'b1;
        end
      end
    end
  end

  // Word array
  always_ff @(posedge iclk) begin
    if (iclkena && wr_en) begin
      mem[wcnt] <= wdata;
    end
  end

  // Asynchronous read
  assign rdata = mem[raddr];

endmodule

//--- common/pc_enc_pkg.sv
`include "pc_enc_config.svh"

package pc_enc_pkg;

  //------------------------------------------------------------
  // Data types
  //------------------------------------------------------------

  // One frame word, bit i of the frame at bits[i % PC_WORD_W]
  typedef struct packed {
    logic [`PC_WORD_W-1:0] bits;
  } word_t;

  // Word address inside a frame
  typedef logic [`PC_ADDR_W-1:0] addr_t;

  //------------------------------------------------------------
  // Engine command
  //------------------------------------------------------------

  // ALU operations
  typedef enum logic [1:0] {
    NOP   = 2'd0,
    LOAD  = 2'd1,
    XOR   = 2'd2,
    STORE = 2'd3
  } alu_opcode_t;

  // Registered in controller, executed by ALU one edge later
  typedef struct packed {
    alu_opcode_t opcode;
    addr_t       addr_a;
    addr_t       addr_b;
  } alu_cmd_t;

endpackage

//--- common/pc_enc_config.svh
`ifndef PC_ENC_CONFIG_SVH
`define PC_ENC_CONFIG_SVH

//------------------------------------------------------------
// Frame geometry
//------------------------------------------------------------

// Bits per frame, fixed at compile time
`define PC_N            64

// Bits per word, power of two
`define PC_WORD_W       8

// Derived word count and address width
`define PC_WORDS        (`PC_N / `PC_WORD_W)
`define PC_ADDR_W       $clog2(`PC_WORDS)

// Butterfly stages inside one word
`define PC_WORD_STAGES  $clog2(`PC_WORD_W)

`endif
